//--- logic/frame_pkg.sv
// Shared types and sizes for the byte-stream packet framer
package frame_pkg;

  typedef logic [7:0] byte_t;     // Payload or header byte
  typedef logic [5:0] len_t;      // Packet length, 1 to 63

  // Data queue holds one maximum packet plus one byte
  localparam int unsigned DATA_DEPTH = 64;
  localparam int unsigned LEN_DEPTH  = 8;   // Lengths waiting for output

  // Marker in the top two bits of every header byte
  localparam logic [1:0] HDR_MARK = 2'b10;

  // Framing controller states
  typedef enum logic {
    ST_IDLE,
    ST_PAYLOAD
  } ctrl_state_t;

endpackage

//--- logic/sync_fifo.sv
`timescale 1ns/1ps

// First-word-fall-through queue with an extra wrap bit on both pointers.
// DEPTH must be a power of two so the wrap bit lines up with the index.
module sync_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 16
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     wr_i,      // Write strobe
  input  logic     rd_i,      // Read strobe, pops the current head
  input  payload_t data_i,
  output payload_t data_o,    // Head of queue, valid while not empty

  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned ADDR_W = $clog2(DEPTH);

  payload_t          mem [DEPTH];

  logic [ADDR_W:0]   wr_ptr;
  logic [ADDR_W:0]   rd_ptr;
  logic [ADDR_W-1:0] wr_idx;
  logic [ADDR_W-1:0] rd_idx;
  logic              wr_en;
  logic              rd_en;

  assign wr_idx = wr_ptr[ADDR_W-1:0];
  assign rd_idx = rd_ptr[ADDR_W-1:0];

  // Same index and same lap means nothing stored
  assign empty_o = (wr_ptr == rd_ptr);

  // Same index but writer one lap ahead
  assign full_o = (wr_idx == rd_idx) && (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

  // Strobes that would overflow or underflow are dropped
  assign wr_en = wr_i && !full_o;
  assign rd_en = rd_i && !empty_o;

  assign data_o = mem[rd_idx];   // Head falls through without a read cycle

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- logic/pkt_len_counter.sv
`timescale 1ns/1ps

// Counts the accepted bytes of the packet being received and pushes
// the finished length into the length queue on the last byte
module pkt_len_counter import frame_pkg::*; (
  input  logic clk,
  input  logic rst_n,

  input  logic in_wr_i,       // Source write strobe
  input  logic in_last_i,     // Last byte of packet, sampled with in_wr_i
  input  logic data_full_i,   // Data queue full
  input  logic len_full_i,    // Length queue full

  output logic in_full_o,     // Back-pressure level to the source
  output logic accept_o,      // Data queue write strobe
  output logic len_wr_o,      // Length queue write strobe
  output len_t len_o          // Length value to push
);

  len_t byte_cnt;             // Bytes accepted so far in this packet

  // Either queue being full stops the source
  assign in_full_o = data_full_i || len_full_i;

  assign accept_o = in_wr_i && !in_full_o;

  // The last byte counts itself
  assign len_wr_o = accept_o && in_last_i;
  assign len_o    = byte_cnt + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      byte_cnt <= '0;
    end else if (accept_o) begin
      if (in_last_i) begin
        byte_cnt <= '0;       // Next byte starts a new packet
      end else begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

endmodule

//--- logic/frame_ctrl.sv
`timescale 1ns/1ps

// Framing controller. Pops one length per packet and sends a header
// byte, then pops and sends the stored payload one byte per enabled cycle.
module frame_ctrl import frame_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  input  logic  out_en_i,      // Sink enable level
  input  logic  len_empty_i,   // Length queue empty
  input  len_t  len_i,         // Length queue head
  input  byte_t data_i,        // Data queue head

  output logic  len_rd_o,      // Length queue pop
  output logic  data_rd_o,     // Data queue pop

  output logic  out_valid_o,   // One pulse per emitted byte
  output logic  out_hdr_o,     // Marks the header byte
  output logic  out_last_o,    // Marks the final payload byte
  output byte_t out_data_o
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  len_t        remain;         // Payload bytes still to send
  len_t        remain_nxt;

  logic        valid_nxt;
  logic        hdr_nxt;
  logic        last_nxt;
  byte_t       data_nxt;

  always_comb begin
    state_nxt  = state;
    remain_nxt = remain;
    len_rd_o   = 1'b0;
    data_rd_o  = 1'b0;
    valid_nxt  = 1'b0;
    hdr_nxt    = 1'b0;
    last_nxt   = 1'b0;
    data_nxt   = out_data_o;   // Hold the last byte when nothing is sent

    case (state)
      ST_IDLE: begin
        // A queued length means its whole payload is already stored
        if (out_en_i && !len_empty_i) begin
          len_rd_o   = 1'b1;
          valid_nxt  = 1'b1;
          hdr_nxt    = 1'b1;
          data_nxt   = {HDR_MARK, len_i};
          remain_nxt = len_i;
          state_nxt  = ST_PAYLOAD;
        end
      end

      ST_PAYLOAD: begin
        if (out_en_i) begin
          data_rd_o  = 1'b1;
          valid_nxt  = 1'b1;
          data_nxt   = data_i;
          remain_nxt = remain - 1'b1;
          if (remain == len_t'(1)) begin
            last_nxt  = 1'b1;
            state_nxt = ST_IDLE;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      remain      <= '0;
      out_valid_o <= 1'b0;
      out_hdr_o   <= 1'b0;
      out_last_o  <= 1'b0;
    end else begin
      state       <= state_nxt;
      remain      <= remain_nxt;
      out_valid_o <= valid_nxt;
      out_hdr_o   <= hdr_nxt;
      out_last_o  <= last_nxt;
    end
  end

  always_ff @(posedge clk) begin
    out_data_o <= data_nxt;
  end

endmodule

//--- logic/frame_top.sv
`timescale 1ns/1ps

// Packet framer top level.
// Input bytes go to the data queue, the packet lengths to the length queue,
// and the controller rebuilds the stream as header plus payload.
module frame_top import frame_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  input  logic  in_wr_i,
  input  logic  in_last_i,
  input  byte_t in_data_i,
  output logic  in_full_o,

  input  logic  out_en_i,
  output logic  out_valid_o,
  output logic  out_hdr_o,
  output logic  out_last_o,
  output byte_t out_data_o
);

  logic  data_wr;
  logic  data_rd;
  logic  data_full;
  byte_t data_head;

  logic  len_wr;
  logic  len_rd;
  logic  len_full;
  logic  len_empty;
  len_t  len_in;
  len_t  len_head;

  pkt_len_counter u_len_cnt (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_wr_i     (in_wr_i),
    .in_last_i   (in_last_i),
    .data_full_i (data_full),
    .len_full_i  (len_full),
    .in_full_o   (in_full_o),
    .accept_o    (data_wr),
    .len_wr_o    (len_wr),
    .len_o       (len_in)
  );

  // A queued length already implies its payload is stored
  sync_fifo #(
    .payload_t (byte_t),
    .DEPTH     (DATA_DEPTH)
  ) u_data_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (data_wr),
    .rd_i    (data_rd),
    .data_i  (in_data_i),
    .data_o  (data_head),
    .empty_o (),
    .full_o  (data_full)
  );

  sync_fifo #(
    .payload_t (len_t),
    .DEPTH     (LEN_DEPTH)
  ) u_len_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (len_wr),
    .rd_i    (len_rd),
    .data_i  (len_in),
    .data_o  (len_head),
    .empty_o (len_empty),
    .full_o  (len_full)
  );

  frame_ctrl u_frame_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .out_en_i    (out_en_i),
    .len_empty_i (len_empty),
    .len_i       (len_head),
    .data_i      (data_head),
    .len_rd_o    (len_rd),
    .data_rd_o   (data_rd),
    .out_valid_o (out_valid_o),
    .out_hdr_o   (out_hdr_o),
    .out_last_o  (out_last_o),
    .out_data_o  (out_data_o)
  );

endmodule

//--- dv/frame_tb_tasks.svh
// Reference model queues, filled when a packet is complete at the source
byte_t exp_data_q[$];
logic  exp_hdr_q[$];
logic  exp_last_q[$];
byte_t pend_q[$];           // Accepted bytes of the packet in progress

int hdr_cnt  = 0;           // Header pulses seen on the output
int last_cnt = 0;           // Last-byte pulses seen on the output

task automatic stop_with_failure(input string why);
  $display("%s", why);
  $display("CHECKS FAILED");
  $fatal(1, "Simulation stopped");
endtask

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
  if (exp !== act) begin
    $display("ERR %s: expected %02h, actual %02h", name, exp, act);
    $display("CHECKS FAILED");
    $fatal(1, "Byte mismatch");
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    $display("ERR %s: expected %b, actual %b", name, exp, act);
    $display("CHECKS FAILED");
    $fatal(1, "Flag mismatch");
  end
endtask

task automatic check_count(input string name, input int exp, input int act);
  if (exp != act) begin
    $display("ERR %s: expected %0d, actual %0d", name, exp, act);
    $display("CHECKS FAILED");
    $fatal(1, "Count mismatch");
  end
endtask

// Header first, then the payload in the order it was accepted
task automatic queue_packet();
  len_t len;
  int   i;
  len = len_t'(pend_q.size());
  exp_data_q.push_back({HDR_MARK, len});
  exp_hdr_q.push_back(1'b1);
  exp_last_q.push_back(1'b0);
  for (i = 0; i < pend_q.size(); i++) begin
    exp_data_q.push_back(pend_q[i]);
    exp_hdr_q.push_back(1'b0);
    exp_last_q.push_back(i == pend_q.size() - 1);
  end
  pend_q.delete();
endtask

task automatic compare_output();
  byte_t exp_b;
  logic  exp_h;
  logic  exp_l;
  if (exp_data_q.size() == 0) begin
    stop_with_failure("Output byte arrived while no byte was expected");
  end else begin
    exp_b = exp_data_q.pop_front();
    exp_h = exp_hdr_q.pop_front();
    exp_l = exp_last_q.pop_front();
    check_byte({test_name, " data"}, exp_b, out_data_o);
    check_flag({test_name, " hdr"}, exp_h, out_hdr_o);
    check_flag({test_name, " last"}, exp_l, out_last_o);
  end
endtask

//--- dv/frame_tb.sv
`timescale 1ns/1ps

module frame_tb import frame_pkg::*; ();

  // Packet table layout, one entry per packet over all tests
  localparam int NUM_PKT  = 153;
  localparam int B3_FIRST = 4;
  localparam int B3_COUNT = 100;
  localparam int B4_FIRST = 104;
  localparam int B4_COUNT = 40;
  localparam int B5_FIRST = 144;
  localparam int B5_COUNT = 9;

  logic  clk;
  logic  rst_n;
  logic  in_wr_i;
  logic  in_last_i;
  byte_t in_data_i;
  logic  in_full_o;
  logic  out_en_i;
  logic  out_valid_o;
  logic  out_hdr_o;
  logic  out_last_o;
  byte_t out_data_o;

  int    seed;
  string test_name;
  int    pkt_len [NUM_PKT];
  int    cycle_cnt   = 0;
  int    cycle_limit = 0;
  logic  batch_done;
  logic  full_seen;          // in_full_o observed high during back-pressure
  int    hdr_base;
  int    last_base;

  `include "frame_tb_tasks.svh"

  frame_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_wr_i     (in_wr_i),
    .in_last_i   (in_last_i),
    .in_data_i   (in_data_i),
    .in_full_o   (in_full_o),
    .out_en_i    (out_en_i),
    .out_valid_o (out_valid_o),
    .out_hdr_o   (out_hdr_o),
    .out_last_o  (out_last_o),
    .out_data_o  (out_data_o)
  );

  always #2 clk = ~clk;

  // Outputs are registered, so they are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid_o) compare_output();
      if (out_hdr_o) hdr_cnt++;     // Flag pulses counted with or without valid
      if (out_last_o) last_cnt++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      stop_with_failure($sformatf("Timeout: run exceeded %0d cycles", cycle_limit));
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      in_wr_i   = 1'b0;
      in_last_i = 1'b0;
    end
  endtask

  // Offers one byte, holding off while the queues are full
  task automatic write_byte(input logic last);
    byte_t d;
    @(negedge clk);
    while (in_full_o) begin
      in_wr_i = 1'b0;
      @(negedge clk);
    end
    d         = byte_t'($random(seed));
    in_wr_i   = 1'b1;
    in_data_i = d;
    in_last_i = last;
    pend_q.push_back(d);      // Accepted, since in_full_o was low
    if (last) queue_packet();
  endtask

  task automatic send_packet(input int len, input int max_gap);
    int i;
    for (i = 0; i < len; i++) begin
      idle_cycles(rand_range(0, max_gap));
      write_byte(i == len - 1);
    end
  endtask

  task automatic send_batch(input int first, input int count, input int max_gap);
    int i;
    for (i = first; i < first + count; i++) begin
      send_packet(pkt_len[i], max_gap);
    end
    idle_cycles(1);           // Drop the write strobe
  endtask

  task automatic hold_and_watch(input int n, input string name);
    repeat (n) begin
      @(negedge clk);
      check_flag(name, 1'b0, out_valid_o);
    end
  endtask

  task automatic wait_drained();
    while (exp_data_q.size() != 0) @(negedge clk);
  endtask

  task automatic toggle_enable();
    int r;
    while (!batch_done) begin
      @(negedge clk);
      r        = $random(seed);
      out_en_i = r[0];
      if (in_full_o) full_seen = 1'b1;
    end
    out_en_i = 1'b1;
  endtask

  // Length queue fills, the source stalls, then the sink opens
  task automatic enable_after_full();
    while (!in_full_o) @(negedge clk);
    repeat (5) begin
      @(negedge clk);
      check_flag("len_queue_full no output", 1'b0, out_valid_o);
      check_flag("len_queue_full in_full_o", 1'b1, in_full_o);
    end
    out_en_i = 1'b1;
  endtask

  initial begin
    int i;
    int total;
    seed      = 32'hac480da4;
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_wr_i   = 1'b0;
    in_last_i = 1'b0;
    in_data_i = '0;
    out_en_i  = 1'b0;
    test_name = "reset";

    pkt_len[0] = 5;
    pkt_len[1] = 9;
    pkt_len[2] = 1;
    pkt_len[3] = 63;
    for (i = B3_FIRST; i < B5_FIRST; i++) pkt_len[i] = rand_range(1, 63);
    for (i = B5_FIRST; i < NUM_PKT; i++) pkt_len[i] = rand_range(1, 3);
    total = 0;
    for (i = 0; i < NUM_PKT; i++) total += pkt_len[i] + 1;   // Payload plus header
    cycle_limit = 4 * total + 200;

    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("reset out_valid_o", 1'b0, out_valid_o);
    check_flag("reset in_full_o", 1'b0, in_full_o);

    test_name = "enable_low";
    send_batch(0, 2, 0);
    hold_and_watch(20, "enable_low no output");
    out_en_i = 1'b1;
    wait_drained();

    test_name = "min_max_len";
    send_batch(2, 2, 0);
    wait_drained();

    test_name = "random_packets";
    hdr_base  = hdr_cnt;
    last_base = last_cnt;
    send_batch(B3_FIRST, B3_COUNT, 2);
    wait_drained();
    check_count("random_packets headers", B3_COUNT, hdr_cnt - hdr_base);
    check_count("random_packets lasts", B3_COUNT, last_cnt - last_base);

    test_name  = "backpressure";
    batch_done = 1'b0;
    full_seen  = 1'b0;
    fork
      begin
        send_batch(B4_FIRST, B4_COUNT, 0);
        batch_done = 1'b1;
      end
      toggle_enable();
    join
    wait_drained();
    check_flag("backpressure in_full_o seen", 1'b1, full_seen);

    test_name = "len_queue_full";
    out_en_i  = 1'b0;
    hdr_base  = hdr_cnt;
    fork
      send_batch(B5_FIRST, B5_COUNT, 0);
      enable_after_full();
    join
    wait_drained();
    check_count("len_queue_full headers", B5_COUNT, hdr_cnt - hdr_base);

    idle_cycles(10);          // Any stray byte would show up here
    if (exp_data_q.size() == 0 && pend_q.size() == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_with_failure("Expected bytes were never emitted by the DUT");
    end
  end

endmodule

//--- src.f
+incdir+dv
logic/frame_pkg.sv
logic/sync_fifo.sv
logic/pkt_len_counter.sv
logic/frame_ctrl.sv
logic/frame_top.sv
dv/frame_tb.sv

//--- Makefile
# Verilator build and run for the packet framer

VERILATOR ?= verilator
TOP       ?= frame_tb
DUT_TOP   ?= frame_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES   := $(wildcard logic/*.sv dv/*.sv dv/*.svh)
RTL_FILES := $(shell grep '^logic/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
